//--- verilog/lsu_pkg.sv
/* load/store unit shared definitions */

package lsu_pkg;

  // data and address width
  parameter int XLEN   = 64;
  parameter int RIDX_W = 5;

  // memory opcodes, OP_NONE for anything that does not touch memory
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    LB      = 4'd1,
    LBU     = 4'd2,
    LH      = 4'd3,
    LHU     = 4'd4,
    LW      = 4'd5,
    LWU     = 4'd6,
    LD      = 4'd7,
    SB      = 4'd8,
    SH      = 4'd9,
    SW      = 4'd10,
    SD      = 4'd11
  } mem_op_e;

  // address map, both windows compared under WINDOW_MASK
  parameter logic [63:0] MEM_BASE    = 64'h0000_0000_8000_0000;
  parameter logic [63:0] MMIO_BASE   = 64'h0000_0000_0200_0000;
  parameter logic [63:0] WINDOW_MASK = 64'h0000_0000_FF00_0000;

  // clint register offsets inside the timer window
  parameter logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  parameter logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

  // size code is 3 bits holding bytes minus one:
  // 0 byte, 1 half, 3 word, 7 doubleword

endpackage

//--- verilog/mem_access_unit.sv
/* data cache request unit */

`timescale 1ns/1ps

module mem_access_unit
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic [XLEN-1:0] i_addr,
  input  logic [2:0]      i_size,
  input  logic            i_we,
  input  logic [XLEN-1:0] i_wdata,
  input  logic            i_retire,
  output logic            o_done,
  output logic [XLEN-1:0] o_rdata,
  output logic            o_dc_req,
  output logic [XLEN-1:0] o_dc_addr,
  output logic            o_dc_we,
  output logic [7:0]      o_dc_strb,
  output logic [XLEN-1:0] o_dc_wdata,
  input  logic            i_dc_ack,
  input  logic [XLEN-1:0] i_dc_rdata
);

  typedef enum logic [1:0] {IDLE, REQ, HOLD} unit_state_e;

  unit_state_e state;
  logic [2:0]  lane;
  logic [7:0]  size_mask;

  // bytes covered by the access before lane shift
  always_comb begin
    case (i_size)
      3'd0:    size_mask = 8'h01;
      3'd1:    size_mask = 8'h03;
      3'd3:    size_mask = 8'h0F;
      default: size_mask = 8'hFF;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (i_start) state <= REQ;
        REQ:  if (i_dc_ack) state <= HOLD;
        HOLD: if (i_retire) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // request payload, held while waiting for ack
  always_ff @(posedge clk) begin
    if (state == IDLE && i_start) begin
      lane       <= i_addr[2:0];
      o_dc_addr  <= i_addr;
      o_dc_we    <= i_we;
      o_dc_strb  <= size_mask << i_addr[2:0];
      o_dc_wdata <= i_wdata << {i_addr[2:0], 3'b000};
    end
    if (state == REQ && i_dc_ack) begin
      o_rdata <= i_dc_rdata >> {lane, 3'b000};
    end
  end

  assign o_dc_req = (state == REQ);
  assign o_done   = (state == HOLD);

endmodule

//--- verilog/clint_mmio.sv
/* core local timer */

`timescale 1ns/1ps

module clint_mmio
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            i_sel,
  input  logic            i_we,
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rdata,
  output logic            o_timer_irq
);

  logic [XLEN-1:0] mtime;
  logic [XLEN-1:0] mtimecmp;
  logic [15:0]     ofs;
  logic            hit_mtime;
  logic            hit_mtimecmp;

  assign ofs          = i_addr[15:0];
  assign hit_mtime    = (ofs == CLINT_MTIME_OFS);
  assign hit_mtimecmp = (ofs == CLINT_MTIMECMP_OFS);

  // a write to mtime takes priority over the increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (i_sel && i_we && hit_mtime) begin
      mtime <= i_wdata;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= '1;
    end else if (i_sel && i_we && hit_mtimecmp) begin
      mtimecmp <= i_wdata;
    end
  end

  // read data lands one cycle after select
  always_ff @(posedge clk) begin
    if (i_sel && !i_we) begin
      if (hit_mtime) begin
        o_rdata <= mtime;
      end else if (hit_mtimecmp) begin
        o_rdata <= mtimecmp;
      end else begin
        o_rdata <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_timer_irq <= 1'b0;
    end else begin
      o_timer_irq <= (mtime >= mtimecmp);
    end
  end

endmodule

//--- verilog/data_ram.sv
/* fixed latency data RAM */

`timescale 1ns/1ps

module data_ram
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_req,
  input  logic [XLEN-1:0] i_addr,
  input  logic            i_we,
  input  logic [7:0]      i_strb,
  input  logic [XLEN-1:0] i_wdata,
  output logic            o_ack,
  output logic [XLEN-1:0] o_rdata
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = (RAM_LATENCY > 2) ? $clog2(RAM_LATENCY) : 1;

  logic [XLEN-1:0]  mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] cnt;
  logic             busy;
  logic             fire;

  // doubleword index, wraps at the RAM size
  assign idx = IDX_W'((i_addr >> 3) % RAM_WORDS);

  // latency of one fires on the cycle the request is first seen
  assign fire = busy ? (cnt == '0) : (i_req && !o_ack && (RAM_LATENCY == 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      cnt   <= '0;
      o_ack <= 1'b0;
    end else begin
      o_ack <= fire;
      if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end else if (i_req && !o_ack) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(RAM_LATENCY - 2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (i_we) begin
        for (int b = 0; b < 8; b++) begin
          if (i_strb[b]) mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end else begin
        o_rdata <= mem[idx];
      end
    end
  end

endmodule

//--- verilog/mem_stage.sv
/* memory access stage */

`timescale 1ns/1ps

module mem_stage
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  output logic              o_ready,
  input  mem_op_e           i_op,
  input  logic [XLEN-1:0]   i_op1,
  input  logic [XLEN-1:0]   i_op2,
  input  logic [XLEN-1:0]   i_op3,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [RIDX_W-1:0] i_rd,
  input  logic              i_rd_wen,
  input  logic [XLEN-1:0]   i_rd_wdata,
  output logic              o_valid,
  input  logic              i_ready,
  output logic [XLEN-1:0]   o_pc,
  output logic [RIDX_W-1:0] o_rd,
  output logic              o_rd_wen,
  output logic [XLEN-1:0]   o_rd_wdata,
  output logic              o_skip_commit,
  output logic              o_dc_req,
  output logic [XLEN-1:0]   o_dc_addr,
  output logic              o_dc_we,
  output logic [7:0]        o_dc_strb,
  output logic [XLEN-1:0]   o_dc_wdata,
  input  logic              i_dc_ack,
  input  logic [XLEN-1:0]   i_dc_rdata,
  output logic              o_mmio_sel,
  output logic              o_mmio_we,
  output logic [XLEN-1:0]   o_mmio_addr,
  output logic [XLEN-1:0]   o_mmio_wdata,
  input  logic [XLEN-1:0]   i_mmio_rdata
);

  typedef enum logic [1:0] {IDLE, WAIT_MEM, WAIT_MMIO, DONE} stage_state_e;
  typedef enum logic [1:0] {CH_NONE, CH_MEM, CH_MMIO} chan_e;

  stage_state_e      state;
  chan_e             chan;
  chan_e             chan_q;
  logic              is_load;
  logic              is_store;
  logic [2:0]        size;
  logic [XLEN-1:0]   wdata;
  logic [XLEN-1:0]   addr;
  logic              accept;
  logic              retire;
  logic              mem_done;
  logic [XLEN-1:0]   mem_rdata;
  logic [XLEN-1:0]   mmio_rdata_q;
  logic [XLEN-1:0]   raw;
  mem_op_e           op_q;
  logic [XLEN-1:0]   rd_wdata_q;

  // opcode decode
  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    size     = 3'd0;
    wdata    = '0;
    case (i_op)
      LB, LBU: begin is_load = 1'b1; size = 3'd0; end
      LH, LHU: begin is_load = 1'b1; size = 3'd1; end
      LW, LWU: begin is_load = 1'b1; size = 3'd3; end
      LD:      begin is_load = 1'b1; size = 3'd7; end
      SB: begin is_store = 1'b1; size = 3'd0; wdata = {56'd0, i_op2[7:0]}; end
      SH: begin is_store = 1'b1; size = 3'd1; wdata = {48'd0, i_op2[15:0]}; end
      SW: begin is_store = 1'b1; size = 3'd3; wdata = {32'd0, i_op2[31:0]}; end
      SD: begin is_store = 1'b1; size = 3'd7; wdata = i_op2; end
      default: ;
    endcase
  end

  assign addr = i_op1 + i_op3;

  // channel select from the address windows
  always_comb begin
    if (!(is_load || is_store)) begin
      chan = CH_NONE;
    end else if ((addr & WINDOW_MASK) == MEM_BASE) begin
      chan = CH_MEM;
    end else if ((addr & WINDOW_MASK) == MMIO_BASE) begin
      chan = CH_MMIO;
    end else begin
      chan = CH_NONE;
    end
  end

  assign o_ready = (state == IDLE);
  assign accept  = i_valid && o_ready;
  assign o_valid = (state == DONE) || (state == WAIT_MEM && mem_done);
  assign retire  = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      chan_q <= CH_NONE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            chan_q <= chan;
            case (chan)
              CH_MEM:  state <= WAIT_MEM;
              CH_MMIO: state <= WAIT_MMIO;
              default: state <= DONE;
            endcase
          end
        end
        WAIT_MMIO: state <= DONE;
        WAIT_MEM, DONE: if (retire) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // instruction context, held until the downstream handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      o_pc       <= i_pc;
      o_rd       <= i_rd;
      o_rd_wen   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
      op_q       <= i_op;
    end
    if (state == WAIT_MMIO) begin
      mmio_rdata_q <= i_mmio_rdata;
    end
  end

  // timer access is a single pulse on acceptance
  assign o_mmio_sel   = accept && (chan == CH_MMIO);
  assign o_mmio_we    = is_store;
  assign o_mmio_addr  = addr;
  assign o_mmio_wdata = wdata;

  assign raw = (chan_q == CH_MMIO) ? mmio_rdata_q : mem_rdata;

  // sign or zero extension by opcode
  always_comb begin
    if (chan_q == CH_NONE) begin
      o_rd_wdata = rd_wdata_q;
    end else begin
      case (op_q)
        LB:      o_rd_wdata = {{56{raw[7]}}, raw[7:0]};
        LBU:     o_rd_wdata = {56'd0, raw[7:0]};
        LH:      o_rd_wdata = {{48{raw[15]}}, raw[15:0]};
        LHU:     o_rd_wdata = {48'd0, raw[15:0]};
        LW:      o_rd_wdata = {{32{raw[31]}}, raw[31:0]};
        LWU:     o_rd_wdata = {32'd0, raw[31:0]};
        LD:      o_rd_wdata = raw;
        default: o_rd_wdata = rd_wdata_q;
      endcase
    end
  end

  assign o_skip_commit = (chan_q == CH_MMIO);

  mem_access_unit mem_access_unit_i (
    .clk        (clk),
    .rst        (rst),
    .i_start    (accept && (chan == CH_MEM)),
    .i_addr     (addr),
    .i_size     (size),
    .i_we       (is_store),
    .i_wdata    (wdata),
    .i_retire   (retire),
    .o_done     (mem_done),
    .o_rdata    (mem_rdata),
    .o_dc_req   (o_dc_req),
    .o_dc_addr  (o_dc_addr),
    .o_dc_we    (o_dc_we),
    .o_dc_strb  (o_dc_strb),
    .o_dc_wdata (o_dc_wdata),
    .i_dc_ack   (i_dc_ack),
    .i_dc_rdata (i_dc_rdata)
  );

endmodule

//--- verilog/mem_subsystem.sv
/* memory stage subsystem */

`timescale 1ns/1ps

module mem_subsystem
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  output logic              o_ready,
  input  mem_op_e           i_op,
  input  logic [XLEN-1:0]   i_op1,
  input  logic [XLEN-1:0]   i_op2,
  input  logic [XLEN-1:0]   i_op3,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [RIDX_W-1:0] i_rd,
  input  logic              i_rd_wen,
  input  logic [XLEN-1:0]   i_rd_wdata,
  output logic              o_valid,
  input  logic              i_ready,
  output logic [XLEN-1:0]   o_pc,
  output logic [RIDX_W-1:0] o_rd,
  output logic              o_rd_wen,
  output logic [XLEN-1:0]   o_rd_wdata,
  output logic              o_skip_commit,
  output logic              o_timer_irq
);

  logic            dc_req;
  logic [XLEN-1:0] dc_addr;
  logic            dc_we;
  logic [7:0]      dc_strb;
  logic [XLEN-1:0] dc_wdata;
  logic            dc_ack;
  logic [XLEN-1:0] dc_rdata;
  logic            mmio_sel;
  logic            mmio_we;
  logic [XLEN-1:0] mmio_addr;
  logic [XLEN-1:0] mmio_wdata;
  logic [XLEN-1:0] mmio_rdata;

  mem_stage mem_stage_i (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_op          (i_op),
    .i_op1         (i_op1),
    .i_op2         (i_op2),
    .i_op3         (i_op3),
    .i_pc          (i_pc),
    .i_rd          (i_rd),
    .i_rd_wen      (i_rd_wen),
    .i_rd_wdata    (i_rd_wdata),
    .o_valid       (o_valid),
    .i_ready       (i_ready),
    .o_pc          (o_pc),
    .o_rd          (o_rd),
    .o_rd_wen      (o_rd_wen),
    .o_rd_wdata    (o_rd_wdata),
    .o_skip_commit (o_skip_commit),
    .o_dc_req      (dc_req),
    .o_dc_addr     (dc_addr),
    .o_dc_we       (dc_we),
    .o_dc_strb     (dc_strb),
    .o_dc_wdata    (dc_wdata),
    .i_dc_ack      (dc_ack),
    .i_dc_rdata    (dc_rdata),
    .o_mmio_sel    (mmio_sel),
    .o_mmio_we     (mmio_we),
    .o_mmio_addr   (mmio_addr),
    .o_mmio_wdata  (mmio_wdata),
    .i_mmio_rdata  (mmio_rdata)
  );

  clint_mmio clint_mmio_i (
    .clk         (clk),
    .rst         (rst),
    .i_sel       (mmio_sel),
    .i_we        (mmio_we),
    .i_addr      (mmio_addr),
    .i_wdata     (mmio_wdata),
    .o_rdata     (mmio_rdata),
    .o_timer_irq (o_timer_irq)
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) data_ram_i (
    .clk     (clk),
    .rst     (rst),
    .i_req   (dc_req),
    .i_addr  (dc_addr),
    .i_we    (dc_we),
    .i_strb  (dc_strb),
    .i_wdata (dc_wdata),
    .o_ack   (dc_ack),
    .o_rdata (dc_rdata)
  );

endmodule

//--- verification/mem_checker.sv
/* downstream result checker */

`timescale 1ns/1ps

module mem_checker
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  input  logic              i_ready,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [RIDX_W-1:0] i_rd,
  input  logic              i_rd_wen,
  input  logic [XLEN-1:0]   i_rd_wdata,
  input  logic              i_skip,
  input  logic              i_timer_irq,
  output int                o_passes,
  output int                o_fails,
  output int                o_handshakes,
  output int                o_errors
);

  logic [XLEN-1:0]   exp_pc_q [$];
  logic [RIDX_W-1:0] exp_rd_q [$];
  logic              exp_wen_q [$];
  logic [XLEN-1:0]   exp_data_q [$];
  logic              exp_skip_q [$];
  // {check enable, expected level}
  logic [1:0]        exp_irq_q [$];
  logic              hold_q = 1'b0;
  logic [XLEN-1:0]   pc_q;
  logic [RIDX_W-1:0] rd_q;
  logic              wen_q;
  logic [XLEN-1:0]   data_q;
  logic              skip_q;
  int                passes = 0;
  int                fails = 0;
  int                handshakes = 0;
  int                errors = 0;
  int                irq_wait = 0;
  int                irq_test = 0;
  logic              irq_level = 1'b0;
  bit                irq_bad = 1'b0;

  assign o_passes     = passes;
  assign o_fails      = fails;
  assign o_handshakes = handshakes;
  assign o_errors     = errors;

  task automatic push_expect(input logic [XLEN-1:0] pc, input logic [RIDX_W-1:0] rd,
                             input logic rd_wen, input logic [XLEN-1:0] data,
                             input logic skip, input logic chk_irq, input logic level);
    exp_pc_q.push_back(pc);
    exp_rd_q.push_back(rd);
    exp_wen_q.push_back(rd_wen);
    exp_data_q.push_back(data);
    exp_skip_q.push_back(skip);
    exp_irq_q.push_back({chk_irq, level});
  endtask

  function automatic bit field_ok(input string name, input logic [XLEN-1:0] exp,
                                  input logic [XLEN-1:0] got);
    if (got !== exp) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic close_test(input int idx, input bit bad);
    if (bad) begin
      fails++;
    end else begin
      passes++;
      $display("PASS t=%0t test %0d", $time, idx);
    end
  endtask

  always @(posedge clk) begin
    bit         bad;
    logic [1:0] irq_chk;
    if (rst) begin
      hold_q <= 1'b0;
    end else begin
      // stalled outputs must not move
      if (hold_q && (!i_valid || i_pc !== pc_q || i_rd !== rd_q || i_rd_wen !== wen_q ||
                     i_rd_wdata !== data_q || i_skip !== skip_q)) begin
        $display("outputs changed while the stage was stalled at t=%0t", $time);
        errors++;
      end
      hold_q <= i_valid && !i_ready;
      pc_q   <= i_pc;
      rd_q   <= i_rd;
      wen_q  <= i_rd_wen;
      data_q <= i_rd_wdata;
      skip_q <= i_skip;

      if (irq_wait > 0) begin
        irq_wait--;
        if (irq_wait == 0) begin
          if (!field_ok("o_timer_irq", 64'(irq_level), 64'(i_timer_irq))) irq_bad = 1'b1;
          close_test(irq_test, irq_bad);
        end
      end

      if (i_valid && i_ready) begin
        handshakes++;
        if (exp_pc_q.size() == 0) begin
          $display("handshake at t=%0t with no instruction outstanding", $time);
          errors++;
        end else begin
          bad = 1'b0;
          if (!field_ok("o_pc", exp_pc_q.pop_front(), i_pc)) bad = 1'b1;
          if (!field_ok("o_rd", 64'(exp_rd_q.pop_front()), 64'(i_rd))) bad = 1'b1;
          if (!field_ok("o_rd_wen", 64'(exp_wen_q.pop_front()), 64'(i_rd_wen))) bad = 1'b1;
          if (!field_ok("o_rd_wdata", exp_data_q.pop_front(), i_rd_wdata)) bad = 1'b1;
          if (!field_ok("o_skip_commit", 64'(exp_skip_q.pop_front()), 64'(i_skip))) bad = 1'b1;
          irq_chk = exp_irq_q.pop_front();
          // irq verdict two cycles after the handshake
          if (irq_chk[1]) begin
            irq_wait  = 2;
            irq_level = irq_chk[0];
            irq_bad   = bad;
            irq_test  = handshakes;
          end else begin
            close_test(handshakes, bad);
          end
        end
      end
    end
  end

endmodule

//--- verification/tb_mem_subsystem.sv
/* memory stage testbench */

`timescale 1ns/1ps

module tb_mem_subsystem
  import lsu_pkg::*;
();

  localparam int RAM_WORDS   = 256;
  localparam int RAM_LATENCY = 3;
  localparam int CLK_PERIOD  = 4;

  typedef struct packed {
    mem_op_e           op;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op3;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   pc;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   exp_wdata;
    logic              exp_skip;
    logic              chk_irq;
    logic              exp_irq;
  } row_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              i_valid;
  logic              o_ready;
  mem_op_e           i_op;
  logic [XLEN-1:0]   i_op1;
  logic [XLEN-1:0]   i_op2;
  logic [XLEN-1:0]   i_op3;
  logic [XLEN-1:0]   i_pc;
  logic [RIDX_W-1:0] i_rd;
  logic              i_rd_wen;
  logic [XLEN-1:0]   i_rd_wdata;
  logic              o_valid;
  logic              i_ready;
  logic [XLEN-1:0]   o_pc;
  logic [RIDX_W-1:0] o_rd;
  logic              o_rd_wen;
  logic [XLEN-1:0]   o_rd_wdata;
  logic              o_skip_commit;
  logic              o_timer_irq;
  int                passes;
  int                fails;
  int                handshakes;
  int                errors;

  row_t              rows [$];
  logic [XLEN-1:0]   shadow [RAM_WORDS];
  // mtimecmp comes out of reset as all ones
  logic [XLEN-1:0]   cmp_model = '1;
  logic [31:0]       lcg_state = 32'd65;
  int                n_rows = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mem_subsystem #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) mem_subsystem_i (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_op          (i_op),
    .i_op1         (i_op1),
    .i_op2         (i_op2),
    .i_op3         (i_op3),
    .i_pc          (i_pc),
    .i_rd          (i_rd),
    .i_rd_wen      (i_rd_wen),
    .i_rd_wdata    (i_rd_wdata),
    .o_valid       (o_valid),
    .i_ready       (i_ready),
    .o_pc          (o_pc),
    .o_rd          (o_rd),
    .o_rd_wen      (o_rd_wen),
    .o_rd_wdata    (o_rd_wdata),
    .o_skip_commit (o_skip_commit),
    .o_timer_irq   (o_timer_irq)
  );

  mem_checker mem_checker_i (
    .clk          (clk),
    .rst          (rst),
    .i_valid      (o_valid),
    .i_ready      (i_ready),
    .i_pc         (o_pc),
    .i_rd         (o_rd),
    .i_rd_wen     (o_rd_wen),
    .i_rd_wdata   (o_rd_wdata),
    .i_skip       (o_skip_commit),
    .i_timer_irq  (o_timer_irq),
    .o_passes     (passes),
    .o_fails      (fails),
    .o_handshakes (handshakes),
    .o_errors     (errors)
  );

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  // keep the accessed bytes, fill the rest with zeros or copies of the top bit
  function automatic logic [XLEN-1:0] extend_load(input mem_op_e op, input logic [XLEN-1:0] raw);
    int              nbytes;
    bit              signed_op;
    logic            fill;
    logic [XLEN-1:0] res;
    case (op)
      LB, LBU: nbytes = 1;
      LH, LHU: nbytes = 2;
      LW, LWU: nbytes = 4;
      default: nbytes = 8;
    endcase
    signed_op = op inside {LB, LH, LW};
    fill      = signed_op && raw[8*nbytes-1];
    for (int i = 0; i < 8; i++) begin
      res[8*i +: 8] = (i < nbytes) ? raw[8*i +: 8] : {8{fill}};
    end
    return res;
  endfunction

  // one row with expectations from a byte-lane model of ram and timer
  task automatic add_op(input mem_op_e op, input logic [XLEN-1:0] base,
                        input logic [XLEN-1:0] ofs, input logic [XLEN-1:0] data = '0,
                        input logic chk_irq = 1'b0, input logic exp_irq = 1'b0);
    row_t            r;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] dw;
    int              idx;
    int              lane;
    int              nbytes;
    bit              is_load;
    bit              is_store;
    bit              in_mem;
    bit              in_mmio;
    addr     = base + ofs;
    is_load  = op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    is_store = op inside {SB, SH, SW, SD};
    in_mem   = (is_load || is_store) && ((addr & WINDOW_MASK) == MEM_BASE);
    in_mmio  = (is_load || is_store) && ((addr & WINDOW_MASK) == MMIO_BASE);
    idx      = int'((addr >> 3) % 64'(RAM_WORDS));
    lane     = int'(addr[2:0]);
    case (op)
      SB:      nbytes = 1;
      SH:      nbytes = 2;
      SW:      nbytes = 4;
      default: nbytes = 8;
    endcase
    r.op        = op;
    r.op1       = base;
    r.op3       = ofs;
    r.op2       = data;
    r.pc        = 64'h1000 + 64'(4 * rows.size());
    r.rd        = RIDX_W'(rows.size());
    r.rd_wen    = (rows.size() % 3) != 0;
    r.rd_wdata  = {32'hC0DE_0000, 32'(rows.size())};
    r.exp_wdata = r.rd_wdata;
    r.exp_skip  = in_mmio;
    r.chk_irq   = chk_irq;
    r.exp_irq   = exp_irq;
    if (in_mem && is_store) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[idx][8*(lane+b) +: 8] = data[8*b +: 8];
      end
    end else if (in_mem && is_load) begin
      dw          = shadow[idx];
      r.exp_wdata = extend_load(op, dw >> (8 * lane));
    end else if (in_mmio && is_store && addr[15:0] == CLINT_MTIMECMP_OFS) begin
      cmp_model = '0;
      for (int b = 0; b < nbytes; b++) begin
        cmp_model[8*b +: 8] = data[8*b +: 8];
      end
    end else if (in_mmio && is_load) begin
      dw          = (addr[15:0] == CLINT_MTIMECMP_OFS) ? cmp_model : '0;
      r.exp_wdata = extend_load(op, dw);
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [XLEN-1:0] outside;
    logic [XLEN-1:0] cmp_ofs;
    outside = 64'h0000_0000_4000_0000;
    cmp_ofs = 64'(CLINT_MTIMECMP_OFS);
    // round trip for every width
    add_op(SD, MEM_BASE, 64'h00, 64'hF1E2_D3C4_B5A6_9788);
    add_op(SD, MEM_BASE, 64'h08, 64'h0123_4567_89AB_CDEF);
    add_op(LD, MEM_BASE, 64'h00);
    add_op(LW, MEM_BASE, 64'h04);
    add_op(LWU, MEM_BASE, 64'h00);
    add_op(LW, MEM_BASE, 64'h0C);
    add_op(LWU, MEM_BASE, 64'h08);
    add_op(LH, MEM_BASE, 64'h02);
    add_op(LHU, MEM_BASE, 64'h06);
    add_op(LH, MEM_BASE, 64'h0E);
    add_op(LB, MEM_BASE, 64'h01);
    add_op(LBU, MEM_BASE, 64'h07);
    add_op(LB, MEM_BASE, 64'h0B);
    add_op(LD, MEM_BASE, 64'h08);
    // partial stores ignore the upper data bits
    add_op(SB, MEM_BASE, 64'h03, 64'hFFFF_FFFF_FFFF_FF5A);
    add_op(SH, MEM_BASE, 64'h0A, 64'h1234_5678_9ABC_BEEF);
    add_op(SW, MEM_BASE, 64'h04, 64'hAAAA_AAAA_0BAD_F00D);
    add_op(LD, MEM_BASE, 64'h00);
    add_op(LD, MEM_BASE, 64'h08);
    // outside address aliases the same ram word as a no-access store
    add_op(SD, MEM_BASE, 64'h10, 64'h5555_6666_7777_8888);
    add_op(OP_NONE, MEM_BASE, 64'h10, 64'hDEAD_BEEF_DEAD_BEEF);
    add_op(SD, outside, 64'h10, 64'hDEAD_BEEF_DEAD_BEEF);
    add_op(LD, outside, 64'h10);
    add_op(LD, MEM_BASE, 64'h10);
    add_op(LD, MEM_BASE, 64'(RAM_WORDS * 8));
    // timer registers and interrupt
    add_op(SD, MMIO_BASE, cmp_ofs, 64'h7FFF_0000_1234_5678, 1'b1, 1'b0);
    add_op(LD, MMIO_BASE, cmp_ofs);
    add_op(LW, MMIO_BASE, cmp_ofs);
    add_op(LD, MMIO_BASE, 64'h0100);
    add_op(SD, MMIO_BASE, cmp_ofs, 64'h0, 1'b1, 1'b1);
    add_op(LD, MMIO_BASE, cmp_ofs);
    add_op(SD, MMIO_BASE, cmp_ofs, '1, 1'b1, 1'b0);
    add_op(LD, MMIO_BASE, cmp_ofs);
  endtask

  // starts 1 ns after a rising edge and returns after the upstream handshake
  task automatic drive_row(input row_t r);
    mem_checker_i.push_expect(r.pc, r.rd, r.rd_wen, r.exp_wdata, r.exp_skip,
                              r.chk_irq, r.exp_irq);
    i_valid    = 1'b1;
    i_op       = r.op;
    i_op1      = r.op1;
    i_op2      = r.op2;
    i_op3      = r.op3;
    i_pc       = r.pc;
    i_rd       = r.rd;
    i_rd_wen   = r.rd_wen;
    i_rd_wdata = r.rd_wdata;
    while (!o_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  initial begin
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_op       = OP_NONE;
    i_op1      = '0;
    i_op2      = '0;
    i_op3      = '0;
    i_pc       = '0;
    i_rd       = '0;
    i_rd_wen   = 1'b0;
    i_rd_wdata = '0;
    i_ready    = 1'b0;
    build_table();
    n_rows = rows.size();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (rows[k]) begin
      drive_row(rows[k]);
    end
    wait (handshakes == n_rows);
    repeat (4) @(posedge clk);
    $display("rows %0d, handshakes %0d, passed %0d, failed %0d, other errors %0d",
             n_rows, handshakes, passes, fails, errors);
    if (handshakes != n_rows) begin
      $display("handshake count does not match the number of rows");
    end
    if (fails == 0 && errors == 0 && handshakes == n_rows) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // downstream stalls of 0 to 3 cycles
  initial begin
    int stall;
    forever begin
      @(posedge clk);
      #1;
      if (o_valid && !rst) begin
        stall = int'(lcg_next() % 4);
        repeat (stall) begin
          @(posedge clk);
          #1;
        end
        i_ready = 1'b1;
        @(posedge clk);
        #1;
        i_ready = 1'b0;
      end
    end
  end

  initial begin
    wait (n_rows > 0);
    #(n_rows * (RAM_LATENCY + 8) * CLK_PERIOD * 4);
    $display("timeout: not all instructions completed in time, %0d of %0d seen",
             handshakes, n_rows);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- mem_subsystem.f
verilog/lsu_pkg.sv
verilog/mem_access_unit.sv
verilog/clint_mmio.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/mem_subsystem.sv
verification/mem_checker.sv
verification/tb_mem_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mem_subsystem
FILELIST  := mem_subsystem.f
OBJ_DIR   := obj_dir
FLAGS     := --binary -j 0 -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
